// ==== filelist.f ====
source/bus_geom_pkg.sv
source/bridge_state_pkg.sv
source/read_engine.sv
source/write_engine.sv
source/cache_bus_bridge.sv
testbench/bus_memory_model.sv
testbench/tb_cache_bus_bridge.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_cache_bus_bridge
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_cache_bus_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache_bus_bridge;

    localparam int LINE_BEATS = 4;
    localparam int ITERATIONS = 60;
    localparam int WAIT_LIMIT = 200;
    localparam logic [31:0] FILL_PATTERN = 32'hA5C3_0F96;

    logic clk;
    logic rst;
    logic icache_ren, dcache_ren, unc_ren;
    logic [31:0] icache_addr, dcache_addr, unc_raddr;
    logic [3:0] dcache_wen, unc_wen;
    logic [31:0] dcache_waddr, unc_waddr, unc_wdata;
    logic [127:0] dcache_wdata;
    wire icache_rvalid, icache_accept, icache_busy, dcache_rvalid, dcache_accept;
    wire dcache_bvalid, unc_rvalid, unc_bvalid, rd_ready, wr_ready;
    wire [127:0] icache_rdata, dcache_rdata;
    wire [31:0] unc_rdata, bus_raddr, bus_rdata, bus_waddr, bus_wdata;
    wire [7:0] bus_rlen, bus_wlen;
    wire [3:0] bus_wstrb;
    wire bus_ren, bus_rvalid, bus_wen, bus_wlast, bus_wresp;

    logic [31:0] shadow [logic [31:0]];
    logic [31:0] lfsr_q = 32'd61;
    int icache_accepts = 0;
    int dcache_accepts = 0;

    cache_bus_bridge #(.LINE_BEATS(LINE_BEATS)) dut0 (
        .clk(clk), .rst(rst),
        .icache_ren_i(icache_ren), .icache_addr_i(icache_addr),
        .icache_rvalid_o(icache_rvalid), .icache_rdata_o(icache_rdata),
        .icache_accept_o(icache_accept), .icache_busy_o(icache_busy),
        .dcache_ren_i(dcache_ren), .dcache_addr_i(dcache_addr),
        .dcache_rvalid_o(dcache_rvalid), .dcache_rdata_o(dcache_rdata),
        .dcache_accept_o(dcache_accept), .dcache_wen_i(dcache_wen),
        .dcache_waddr_i(dcache_waddr), .dcache_wdata_i(dcache_wdata),
        .dcache_bvalid_o(dcache_bvalid),
        .unc_ren_i(unc_ren), .unc_raddr_i(unc_raddr), .unc_rvalid_o(unc_rvalid),
        .unc_rdata_o(unc_rdata), .unc_wen_i(unc_wen), .unc_waddr_i(unc_waddr),
        .unc_wdata_i(unc_wdata), .unc_bvalid_o(unc_bvalid),
        .rd_ready_o(rd_ready), .wr_ready_o(wr_ready),
        .bus_ren_o(bus_ren), .bus_raddr_o(bus_raddr), .bus_rlen_o(bus_rlen),
        .bus_rvalid_i(bus_rvalid), .bus_rdata_i(bus_rdata),
        .bus_wen_o(bus_wen), .bus_waddr_o(bus_waddr), .bus_wlen_o(bus_wlen),
        .bus_wstrb_o(bus_wstrb), .bus_wdata_o(bus_wdata), .bus_wlast_o(bus_wlast),
        .bus_wresp_i(bus_wresp)
    );

    bus_memory_model mem0 (
        .clk(clk), .rst(rst),
        .bus_ren_i(bus_ren), .bus_raddr_i(bus_raddr), .bus_rlen_i(bus_rlen),
        .bus_rvalid_o(bus_rvalid), .bus_rdata_o(bus_rdata),
        .bus_wen_i(bus_wen), .bus_waddr_i(bus_waddr), .bus_wstrb_i(bus_wstrb),
        .bus_wdata_i(bus_wdata), .bus_wlast_i(bus_wlast), .bus_wresp_o(bus_wresp)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        if (!rst && icache_accept)
            icache_accepts++;
        if (!rst && dcache_accept)
            dcache_accepts++;
    end

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = galois_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : (a ^ FILL_PATTERN);
    endfunction

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string msg);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
            $display("Simulation failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s never finished", $time, what);
        $display("Simulation failed");
        $fatal(1, "timeout");
    endtask

    // src 0 icache, 1 dcache, 2 uncached
    task automatic raise_read(input int src, input logic [31:0] addr);
        case (src)
            0: begin icache_ren <= 1'b1; icache_addr <= addr; end
            1: begin dcache_ren <= 1'b1; dcache_addr <= addr; end
            default: begin unc_ren <= 1'b1; unc_raddr <= addr; end
        endcase
    endtask

    task automatic finish_read(input int src, input logic [31:0] addr);
        int beats;
        int seen;
        int waited;
        logic [31:0] base;
        logic [127:0] exp_line;
        beats = (src == 2) ? 1 : LINE_BEATS;
        base = (src == 2) ? addr : (addr & ~32'hF);
        seen = 0;
        waited = 0;
        while (seen < beats)
        begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                report_timeout("read burst");
            if (bus_ren)
            begin
                check_value(bus_raddr, base, "bus read address");
                check_value(bus_rlen, beats - 1, "bus read length");
                if (src == 0)
                    check_value(icache_busy, 1, "icache busy during fill");
            end
            if (bus_rvalid)
                seen++;
        end
        // drop the request at the edge the engine goes idle
        @(posedge clk);
        if (src == 0)
            icache_ren <= 1'b0;
        else if (src == 1)
            dcache_ren <= 1'b0;
        else
            unc_ren <= 1'b0;
        @(negedge clk);
        for (int k = 0; k < LINE_BEATS; k++)
            exp_line[32*k +: 32] = shadow_word(base + 4 * k);
        if (src == 0)
        begin
            check_value(icache_rvalid, 1, "icache read valid");
            check_value(icache_rdata, exp_line, "icache line");
        end
        else if (src == 1)
        begin
            check_value(dcache_rvalid, 1, "dcache read valid");
            check_value(dcache_rdata, exp_line, "dcache line");
        end
        else
        begin
            check_value(unc_rvalid, 1, "uncached read valid");
            check_value(unc_rdata, shadow_word(addr), "uncached word");
        end
    endtask

    task automatic read_line(input int src, input logic [31:0] addr);
        int ic;
        int dc;
        ic = icache_accepts;
        dc = dcache_accepts;
        @(posedge clk);
        raise_read(src, addr);
        finish_read(src, addr);
        @(posedge clk);
        check_value(icache_accepts, ic + (src == 0), "icache accept count");
        check_value(dcache_accepts, dc + (src == 1), "dcache accept count");
    endtask

    // src 0 line writeback, 1 uncached word
    task automatic write_data(input int src, input logic [31:0] addr,
                              input logic [127:0] data, input logic [3:0] strb);
        int beats;
        int seen;
        int waited;
        logic [31:0] base;
        logic [31:0] word;
        beats = (src == 1) ? 1 : LINE_BEATS;
        base = (src == 1) ? addr : (addr & ~32'hF);
        @(posedge clk);
        if (src == 1)
        begin
            unc_wen <= strb;
            unc_waddr <= addr;
            unc_wdata <= data[31:0];
        end
        else
        begin
            dcache_wen <= 4'hF;
            dcache_waddr <= addr;
            dcache_wdata <= data;
        end
        seen = 0;
        waited = 0;
        while (seen < beats)
        begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                report_timeout("write burst");
            if (bus_wen)
            begin
                check_value(bus_waddr, base, "bus write address");
                check_value(bus_wlen, beats - 1, "bus write length");
                check_value(bus_wstrb, (src == 1) ? strb : 4'hF, "bus write strobes");
            end
            if (bus_wresp)
            begin
                check_value(bus_wdata, data[32*seen +: 32], "bus write data");
                check_value(bus_wlast, seen == beats - 1, "bus write last");
                seen++;
            end
        end
        @(posedge clk);
        if (src == 1)
            unc_wen <= '0;
        else
            dcache_wen <= '0;
        @(negedge clk);
        check_value(dcache_bvalid, 1, "dcache write response");
        check_value(unc_bvalid, src == 1, "uncached write response");
        for (int k = 0; k < beats; k++)
        begin
            word = shadow_word(base + 4 * k);
            for (int b = 0; b < 4; b++)
            begin
                if (src == 0 || strb[b])
                    word[8*b +: 8] = data[32*k + 8*b +: 8];
            end
            shadow[base + 4 * k] = word;
        end
    endtask

    initial
    begin
        logic [31:0] op;
        logic [31:0] ra;
        logic [31:0] wa;
        logic [127:0] wd;
        logic [3:0] ws;
        int ic_start;
        int dc_start;
        clk = 1'b0;
        rst = 1'b1;
        icache_ren = 1'b0;
        dcache_ren = 1'b0;
        unc_ren = 1'b0;
        icache_addr = '0;
        dcache_addr = '0;
        unc_raddr = '0;
        dcache_wen = '0;
        dcache_waddr = '0;
        dcache_wdata = '0;
        unc_wen = '0;
        unc_waddr = '0;
        unc_wdata = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value({rd_ready, wr_ready}, 2'b11, "ready after reset");
        check_value({icache_rvalid, dcache_rvalid, unc_rvalid, dcache_bvalid, unc_bvalid},
                    0, "valid strobes after reset");
        check_value({icache_accept, dcache_accept, icache_busy, bus_ren, bus_wen}, 0,
                    "accept, busy and enables after reset");
        check_value(icache_rdata, 0, "icache line after reset");
        check_value(dcache_rdata, 0, "dcache line after reset");
        check_value(unc_rdata, 0, "uncached word after reset");
        for (int i = 0; i < ITERATIONS; i++)
        begin
            op = take_bits(3);
            ra = {21'h0, 9'(take_bits(9)), 2'b00};
            wa = {22'h0, 8'(take_bits(8)), 2'b00};
            wd = {take_bits(32), take_bits(32), take_bits(32), take_bits(32)};
            ws = 4'(take_bits(4));
            if (ws == 0)
                ws = 4'h1;
            case (op)
                0, 7: read_line(0, ra);
                1: read_line(1, ra);
                2: read_line(2, ra);
                3:
                begin
                    write_data(0, wa, wd, 4'hF);
                    read_line(1, wa);
                end
                4:
                begin
                    write_data(1, wa, wd, ws);
                    read_line(2, wa);
                end
                5:
                begin
                    // all three in one cycle, served in priority order
                    ic_start = icache_accepts;
                    dc_start = dcache_accepts;
                    @(posedge clk);
                    raise_read(0, ra);
                    raise_read(1, wa);
                    raise_read(2, ra ^ 32'h40);
                    finish_read(2, ra ^ 32'h40);
                    check_value(icache_accepts, ic_start, "icache accept before uncached");
                    check_value(dcache_accepts, dc_start, "dcache accept before uncached");
                    finish_read(1, wa);
                    check_value(icache_accepts, ic_start, "icache accept before dcache");
                    check_value(dcache_accepts, dc_start + 1, "dcache accept after uncached");
                    finish_read(0, ra);
                    check_value(icache_accepts, ic_start + 1, "icache accept after dcache");
                    check_value(dcache_accepts, dc_start + 1, "dcache accept during icache");
                end
                default:
                begin
                    fork
                        read_line(1, ra | 32'h400);
                        write_data(0, wa, wd, 4'hF);
                    join
                end
            endcase
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/bus_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_memory_model
(
    input  wire         clk,
    input  wire         rst,
    input  wire         bus_ren_i,
    input  wire  [31:0] bus_raddr_i,
    input  wire  [7:0]  bus_rlen_i,
    output logic        bus_rvalid_o,
    output logic [31:0] bus_rdata_o,
    input  wire         bus_wen_i,
    input  wire  [31:0] bus_waddr_i,
    input  wire  [3:0]  bus_wstrb_i,
    input  wire  [31:0] bus_wdata_i,
    input  wire         bus_wlast_i,
    output logic        bus_wresp_o
);

    localparam logic [31:0] FILL_PATTERN = 32'hA5C3_0F96;

    logic [31:0] mem [logic [31:0]];
    logic [31:0] lfsr_q;
    logic [7:0]  rbeat_q;
    logic [7:0]  wbeat_q;
    logic [1:0]  rdelay_q;
    logic [1:0]  wdelay_q;

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    // two lfsr steps per delay, one per bit
    function logic [1:0] next_delay();
        logic [1:0] d;
        d = '0;
        for (int i = 0; i < 2; i++)
        begin
            lfsr_q = galois_step(lfsr_q);
            d = {d[0], lfsr_q[0]};
        end
        return d;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (mem.exists(a))
            return mem[a];
        return a ^ FILL_PATTERN;
    endfunction

    always @(posedge clk)
    begin
        logic [31:0] merged;
        logic [31:0] waddr;
        if (rst)
        begin
            lfsr_q = 32'd61;
            bus_rvalid_o <= 1'b0;
            bus_rdata_o <= '0;
            bus_wresp_o <= 1'b0;
            rbeat_q <= '0;
            wbeat_q <= '0;
            rdelay_q <= '0;
            wdelay_q <= '0;
        end
        else
        begin
            bus_rvalid_o <= 1'b0;
            bus_wresp_o <= 1'b0;
            // a strobe just sent blocks a second beat in the same cycle
            if (bus_ren_i && !bus_rvalid_o)
            begin
                if (rdelay_q != 0)
                    rdelay_q <= rdelay_q - 1'b1;
                else
                begin
                    bus_rvalid_o <= 1'b1;
                    bus_rdata_o <= read_word(bus_raddr_i + {22'h0, rbeat_q, 2'b00});
                    rbeat_q <= (rbeat_q == bus_rlen_i) ? '0 : rbeat_q + 1'b1;
                    rdelay_q <= next_delay();
                end
            end
            if (bus_wen_i && !bus_wresp_o)
            begin
                if (wdelay_q != 0)
                    wdelay_q <= wdelay_q - 1'b1;
                else
                begin
                    waddr = bus_waddr_i + {22'h0, wbeat_q, 2'b00};
                    merged = read_word(waddr);
                    for (int b = 0; b < 4; b++)
                    begin
                        if (bus_wstrb_i[b])
                            merged[8*b +: 8] = bus_wdata_i[8*b +: 8];
                    end
                    mem[waddr] = merged;
                    bus_wresp_o <= 1'b1;
                    wbeat_q <= bus_wlast_i ? '0 : wbeat_q + 1'b1;
                    wdelay_q <= next_delay();
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_bus_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_bus_bridge #(
    parameter int LINE_BEATS = bus_geom_pkg::LINE_BEATS_DEF
)
(
    input  wire                                            clk,
    input  wire                                            rst,

    // icache read
    input  wire                                            icache_ren_i,
    input  wire  [bus_geom_pkg::ADDR_W-1:0]                icache_addr_i,
    output wire                                            icache_rvalid_o,
    output wire  [LINE_BEATS*bus_geom_pkg::WORD_W-1:0]     icache_rdata_o,
    output wire                                            icache_accept_o,
    output wire                                            icache_busy_o,

    // dcache read and writeback
    input  wire                                            dcache_ren_i,
    input  wire  [bus_geom_pkg::ADDR_W-1:0]                dcache_addr_i,
    output wire                                            dcache_rvalid_o,
    output wire  [LINE_BEATS*bus_geom_pkg::WORD_W-1:0]     dcache_rdata_o,
    output wire                                            dcache_accept_o,
    input  wire  [bus_geom_pkg::STRB_W-1:0]                dcache_wen_i,
    input  wire  [bus_geom_pkg::ADDR_W-1:0]                dcache_waddr_i,
    input  wire  [LINE_BEATS*bus_geom_pkg::WORD_W-1:0]     dcache_wdata_i,
    output wire                                            dcache_bvalid_o,

    // uncached path
    input  wire                                            unc_ren_i,
    input  wire  [bus_geom_pkg::ADDR_W-1:0]                unc_raddr_i,
    output wire                                            unc_rvalid_o,
    output wire  [bus_geom_pkg::WORD_W-1:0]                unc_rdata_o,
    input  wire  [bus_geom_pkg::STRB_W-1:0]                unc_wen_i,
    input  wire  [bus_geom_pkg::ADDR_W-1:0]                unc_waddr_i,
    input  wire  [bus_geom_pkg::WORD_W-1:0]                unc_wdata_i,
    output wire                                            unc_bvalid_o,

    output wire                                            rd_ready_o,
    output wire                                            wr_ready_o,

    // memory bus read channel
    output wire                                            bus_ren_o,
    output wire  [bus_geom_pkg::ADDR_W-1:0]                bus_raddr_o,
    output wire  [bus_geom_pkg::BURST_LEN_W-1:0]           bus_rlen_o,
    input  wire                                            bus_rvalid_i,
    input  wire  [bus_geom_pkg::WORD_W-1:0]                bus_rdata_i,

    // memory bus write channel
    output wire                                            bus_wen_o,
    output wire  [bus_geom_pkg::ADDR_W-1:0]                bus_waddr_o,
    output wire  [bus_geom_pkg::BURST_LEN_W-1:0]           bus_wlen_o,
    output wire  [bus_geom_pkg::STRB_W-1:0]                bus_wstrb_o,
    output wire  [bus_geom_pkg::WORD_W-1:0]                bus_wdata_o,
    output wire                                            bus_wlast_o,
    input  wire                                            bus_wresp_i
);

    // the two channels run independently and share only the line size
    read_engine #(
        .LINE_BEATS(LINE_BEATS)
    ) u_read (
        .*
    );

    write_engine #(
        .LINE_BEATS(LINE_BEATS)
    ) u_write (
        .*
    );

endmodule

`default_nettype wire

// ==== source/write_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_engine #(
    parameter int LINE_BEATS = bus_geom_pkg::LINE_BEATS_DEF
)
(
    input  wire                                            clk,
    input  wire                                            rst,

    input  wire  [bus_geom_pkg::STRB_W-1:0]                dcache_wen_i,
    input  wire  [bus_geom_pkg::ADDR_W-1:0]                dcache_waddr_i,
    input  wire  [LINE_BEATS*bus_geom_pkg::WORD_W-1:0]     dcache_wdata_i,
    output logic                                           dcache_bvalid_o,

    input  wire  [bus_geom_pkg::STRB_W-1:0]                unc_wen_i,
    input  wire  [bus_geom_pkg::ADDR_W-1:0]                unc_waddr_i,
    input  wire  [bus_geom_pkg::WORD_W-1:0]                unc_wdata_i,
    output logic                                           unc_bvalid_o,

    output logic                                           wr_ready_o,

    output logic                                           bus_wen_o,
    output logic [bus_geom_pkg::ADDR_W-1:0]                bus_waddr_o,
    output logic [bus_geom_pkg::BURST_LEN_W-1:0]           bus_wlen_o,
    output logic [bus_geom_pkg::STRB_W-1:0]                bus_wstrb_o,
    output logic [bus_geom_pkg::WORD_W-1:0]                bus_wdata_o,
    output logic                                           bus_wlast_o,
    input  wire                                            bus_wresp_i
);

    import bus_geom_pkg::*;
    import bridge_state_pkg::*;

    localparam int CNT_W = $clog2(LINE_BEATS);
    localparam int LINE_BYTES = LINE_BEATS * STRB_W;
    localparam logic [ADDR_W-1:0] LINE_MASK = ADDR_W'(LINE_BYTES - 1);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(LINE_BEATS - 1);

    wr_state_e        state_q;
    wr_state_e        state_d;
    logic [CNT_W-1:0] beat_q;
    logic             last_beat;

    // uncached word wins over a pending writeback
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            WR_IDLE:
            begin
                if (|unc_wen_i)
                    state_d = WR_UNCACHED;
                else if (|dcache_wen_i)
                    state_d = WR_LINE;
            end
            WR_LINE, WR_UNCACHED:
            begin
                if (bus_wresp_i && bus_wlast_o)
                    state_d = WR_IDLE;
            end
            default:
                state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= WR_IDLE;
            beat_q <= '0;
            dcache_bvalid_o <= 1'b0;
            unc_bvalid_o <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == WR_IDLE)
                beat_q <= '0;
            else if (bus_wresp_i)
                beat_q <= beat_q + 1'b1;
            // dcache also tracks uncached write completion
            dcache_bvalid_o <= bus_wresp_i && bus_wlast_o;
            unc_bvalid_o <= bus_wresp_i && bus_wlast_o && state_q == WR_UNCACHED;
        end
    end

    assign last_beat = (state_q == WR_LINE) && (beat_q == LAST_BEAT);

    assign wr_ready_o = (state_q == WR_IDLE);
    assign bus_wen_o = (state_q != WR_IDLE);
    assign bus_wlast_o = last_beat || (state_q == WR_UNCACHED);
    assign bus_wlen_o = (state_q == WR_UNCACHED) ? '0 : BURST_LEN_W'(LINE_BEATS - 1);
    assign bus_wstrb_o = (state_q == WR_UNCACHED) ? unc_wen_i : '1;
    assign bus_waddr_o = (state_q == WR_UNCACHED) ? unc_waddr_i : (dcache_waddr_i & ~LINE_MASK);

    // current slice of the line by beat index
    assign bus_wdata_o = (state_q == WR_UNCACHED) ? unc_wdata_i :
                         dcache_wdata_i[beat_q*WORD_W +: WORD_W];

endmodule

`default_nettype wire

// ==== source/read_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_engine #(
    parameter int LINE_BEATS = bus_geom_pkg::LINE_BEATS_DEF
)
(
    input  wire                                            clk,
    input  wire                                            rst,

    input  wire                                            icache_ren_i,
    input  wire  [bus_geom_pkg::ADDR_W-1:0]                icache_addr_i,
    output logic                                           icache_rvalid_o,
    output logic [LINE_BEATS*bus_geom_pkg::WORD_W-1:0]     icache_rdata_o,
    output logic                                           icache_accept_o,
    output logic                                           icache_busy_o,

    input  wire                                            dcache_ren_i,
    input  wire  [bus_geom_pkg::ADDR_W-1:0]                dcache_addr_i,
    output logic                                           dcache_rvalid_o,
    output logic [LINE_BEATS*bus_geom_pkg::WORD_W-1:0]     dcache_rdata_o,
    output logic                                           dcache_accept_o,

    input  wire                                            unc_ren_i,
    input  wire  [bus_geom_pkg::ADDR_W-1:0]                unc_raddr_i,
    output logic                                           unc_rvalid_o,
    output logic [bus_geom_pkg::WORD_W-1:0]                unc_rdata_o,

    output logic                                           rd_ready_o,

    output logic                                           bus_ren_o,
    output logic [bus_geom_pkg::ADDR_W-1:0]                bus_raddr_o,
    output logic [bus_geom_pkg::BURST_LEN_W-1:0]           bus_rlen_o,
    input  wire                                            bus_rvalid_i,
    input  wire  [bus_geom_pkg::WORD_W-1:0]                bus_rdata_i
);

    import bus_geom_pkg::*;
    import bridge_state_pkg::*;

    localparam int CNT_W = $clog2(LINE_BEATS);
    localparam int LINE_BYTES = LINE_BEATS * STRB_W;
    localparam logic [ADDR_W-1:0] LINE_MASK = ADDR_W'(LINE_BYTES - 1);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(LINE_BEATS - 1);

    rd_state_e        state_q;
    rd_state_e        state_d;
    logic [CNT_W-1:0] beat_q;
    logic             last_beat;

    // uncached reads are one beat, fills run the full line
    assign last_beat = bus_rvalid_i &&
                       ((state_q == RD_UNCACHED) ||
                        (state_q != RD_IDLE && beat_q == LAST_BEAT));

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            RD_IDLE:
            begin
                if (unc_ren_i)
                    state_d = RD_UNCACHED;
                else if (dcache_ren_i)
                    state_d = RD_DCACHE;
                else if (icache_ren_i)
                    state_d = RD_ICACHE;
            end
            RD_ICACHE, RD_DCACHE, RD_UNCACHED:
            begin
                if (last_beat)
                    state_d = RD_IDLE;
            end
            default:
                state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= RD_IDLE;
            beat_q <= '0;
            icache_rvalid_o <= 1'b0;
            dcache_rvalid_o <= 1'b0;
            unc_rvalid_o <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == RD_IDLE)
                beat_q <= '0;
            else if (bus_rvalid_i)
                beat_q <= beat_q + 1'b1;
            icache_rvalid_o <= last_beat && state_q == RD_ICACHE;
            dcache_rvalid_o <= last_beat && state_q == RD_DCACHE;
            unc_rvalid_o <= last_beat && state_q == RD_UNCACHED;
        end
    end

    // beats land in the granted requester's register only
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            icache_rdata_o <= '0;
            dcache_rdata_o <= '0;
            unc_rdata_o <= '0;
        end
        else if (bus_rvalid_i)
        begin
            case (state_q)
                RD_ICACHE:
                    icache_rdata_o[beat_q*WORD_W +: WORD_W] <= bus_rdata_i;
                RD_DCACHE:
                    dcache_rdata_o[beat_q*WORD_W +: WORD_W] <= bus_rdata_i;
                RD_UNCACHED:
                    unc_rdata_o <= bus_rdata_i;
                default:
                    ;
            endcase
        end
    end

    assign icache_accept_o = (state_q == RD_IDLE) && (state_d == RD_ICACHE);
    assign dcache_accept_o = (state_q == RD_IDLE) && (state_d == RD_DCACHE);
    // icache holds off a flush while this is high
    assign icache_busy_o = (state_q == RD_ICACHE) || (state_d == RD_ICACHE);
    assign rd_ready_o = (state_q == RD_IDLE);

    assign bus_ren_o = (state_q != RD_IDLE);
    assign bus_rlen_o = (state_q == RD_UNCACHED) ? '0 : BURST_LEN_W'(LINE_BEATS - 1);

    always_comb
    begin
        case (state_q)
            RD_UNCACHED:
                bus_raddr_o = unc_raddr_i;
            RD_DCACHE:
                bus_raddr_o = dcache_addr_i & ~LINE_MASK;
            RD_ICACHE:
                bus_raddr_o = icache_addr_i & ~LINE_MASK;
            default:
                bus_raddr_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/bridge_state_pkg.sv ====
`default_nettype none

package bridge_state_pkg;

    // read channel owner
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ICACHE,
        RD_DCACHE,
        RD_UNCACHED
    } rd_state_e;

    // write channel owner
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_LINE,
        WR_UNCACHED
    } wr_state_e;

endpackage

`default_nettype wire

// ==== source/bus_geom_pkg.sv ====
`default_nettype none

package bus_geom_pkg;

    // one bus beat
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int STRB_W = WORD_W / 8;

    // cache line at the default burst size
    localparam int LINE_BEATS_DEF = 4;
    localparam int LINE_W = WORD_W * LINE_BEATS_DEF;

    // low address bits dropped for line alignment
    localparam int LINE_OFS = $clog2(LINE_W / 8);

    // burst length field carries beats minus one
    localparam int BURST_LEN_W = 8;

endpackage

`default_nettype wire
